// File: common/note_lcd_pkg.sv
// Shared types, LCD encodings, delays and note table for the note display; import with ::*
package note_lcd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Types

  typedef logic [15:0] freq_t;  // Frequency word in Hz

  typedef struct packed {
    logic       rs;    // 0 instruction, 1 character data
    logic [7:0] data;
  } lcd_cmd_t;

  // Display bus pins
  typedef struct packed {
    logic       e;
    logic       rs;
    logic [7:0] d;
  } lcd_bus_t;

  typedef struct packed {
    logic [7:0] letter;  // ASCII letter
    logic [7:0] octave;  // ASCII digit
  } note_t;

  typedef enum logic [2:0] {
    SEQ_WAIT, SEQ_CLEAR, SEQ_HOME, SEQ_LETTER, SEQ_NUMBER
  } seq_state_t;

  typedef enum logic [2:0] {
    BUS_POWERUP, BUS_INIT_SET, BUS_INIT_WRITE, BUS_INIT_HOLD,
    BUS_IDLE, BUS_SET, BUS_WRITE, BUS_OFF
  } bus_state_t;

  // HD44780 instruction bytes
  typedef enum logic [7:0] {
    OP_CLEAR      = 8'h01,  // Clear, cursor to 0
    OP_HOME       = 8'h02,
    OP_ENTRY      = 8'h06,  // Cursor moves right
    OP_DISP_OFF   = 8'h08,
    OP_DISP_ON    = 8'h0C,  // Display on, no cursor
    OP_FUNC_8BIT  = 8'h30,  // Wake-up function set
    OP_FUNC_2LINE = 8'h38   // 8-bit, 2 lines, 5x7
  } lcd_opcode_t;

  ////////////////////////////////////////////////////////////////////////////
  // Delays in clk cycles

  localparam int CNT_W = 14;
  localparam logic [CNT_W-1:0] D_SETUP   = CNT_W'(3);     // d/rs before e rises
  localparam logic [CNT_W-1:0] D_ENABLE  = CNT_W'(5);     // e high
  localparam logic [CNT_W-1:0] D_CMD     = CNT_W'(100);
  localparam logic [CNT_W-1:0] D_LONG    = CNT_W'(500);   // First function set, clear
  localparam logic [CNT_W-1:0] D_POWERUP = CNT_W'(10000);

  // Power-up writes and their holds
  localparam int INIT_LEN = 8;
  localparam lcd_opcode_t INIT_OPS [INIT_LEN] = '{
    OP_FUNC_8BIT, OP_FUNC_8BIT, OP_FUNC_8BIT, OP_FUNC_2LINE,
    OP_DISP_OFF, OP_CLEAR, OP_ENTRY, OP_DISP_ON
  };
  localparam logic [CNT_W-1:0] INIT_HOLD [INIT_LEN] = '{
    D_LONG, D_CMD, D_CMD, D_CMD, D_CMD, D_LONG, D_CMD, D_CMD
  };

  ////////////////////////////////////////////////////////////////////////////
  // Note table from C2 up to B5

  localparam freq_t NOTE_LOW   = 16'd62;
  localparam int    NOTE_COUNT = 28;
  localparam freq_t NOTE_UPPER [NOTE_COUNT] = '{   // Inclusive upper bounds
    16'd69,  16'd78,  16'd85,  16'd93,  16'd104, 16'd117, 16'd127,
    16'd139, 16'd156, 16'd170, 16'd186, 16'd208, 16'd234, 16'd255,
    16'd278, 16'd312, 16'd340, 16'd371, 16'd416, 16'd467, 16'd509,
    16'd555, 16'd623, 16'd679, 16'd741, 16'd832, 16'd934, 16'd1046
  };
  localparam logic [7:0] NOTE_LETTERS [7] = '{"C", "D", "E", "F", "G", "A", "B"};
  localparam logic [7:0] OCTAVE_BASE = "2";   // Octave of entry 0
  localparam logic [7:0] CHAR_SPACE  = 8'h20; // Out of range

endpackage

// File: verilog/spi_freq_rx.sv
// SPI receiver for the 16-bit frequency word; pulses freq_strobe once the new word is stable
module spi_freq_rx import note_lcd_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  sclk,
  input  logic  sdi,
  input  logic  cs,
  output freq_t freq,
  output logic  freq_strobe
);

  freq_t      shift;       // sclk domain
  logic [1:0] cs_sync;     // Two-flop synchronizer
  logic       cs_last;
  logic       load;        // Registered cs rise
  logic [1:0] strobe_cnt;  // Cycles until strobe

  // Shift in MSB first while selected
  always_ff @(posedge sclk) begin
    if (!cs) shift <= {shift[14:0], sdi};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cs_sync     <= 2'b11;  // cs idles high
      cs_last     <= 1'b1;
      load        <= 1'b0;
      strobe_cnt  <= '0;
      freq_strobe <= 1'b0;
    end else begin
      cs_sync <= {cs_sync[0], cs};
      cs_last <= cs_sync[1];
      load    <= cs_sync[1] && !cs_last;  // Frame end
      if (load) strobe_cnt <= 2'd2;        // Let the decoder settle
      else if (strobe_cnt != 2'd0) strobe_cnt <= strobe_cnt - 1'b1;
      freq_strobe <= (strobe_cnt == 2'd1);
    end
  end

  // sclk is still after cs rises, so shift is stable here
  always_ff @(posedge clk) begin
    if (load) freq <= shift;
  end

endmodule

// File: verilog/note_decoder.sv
// Combinational frequency to note lookup; gives letter and octave, or two spaces out of range
module note_decoder import note_lcd_pkg::*; (
  input  freq_t freq,
  output note_t note
);

  typedef logic [$clog2(NOTE_COUNT)-1:0] idx_t;

  idx_t       idx;         // Matching table entry
  logic       hit;         // Some bound at or above freq
  logic       in_range;
  logic [2:0] letter_sel;

  always_comb begin
    idx = '0;
    hit = 1'b0;
    // Scan downward so the lowest matching bound wins
    for (int i = NOTE_COUNT - 1; i >= 0; i--) begin
      if (freq <= NOTE_UPPER[i]) begin
        idx = idx_t'(i);
        hit = 1'b1;
      end
    end
  end

  assign in_range = hit && (freq >= NOTE_LOW);

  // Seven letters per octave
  assign letter_sel = 3'(idx % idx_t'(7));

  assign note.letter = in_range ? NOTE_LETTERS[letter_sel] : CHAR_SPACE;
  assign note.octave = in_range ? OCTAVE_BASE + 8'(idx / idx_t'(7)) : CHAR_SPACE;

endmodule

// File: lcd/lcd_sequencer.sv
// Per-note sequencer; latches a decoded note and hands clear, home, letter, octave to the bus FSM
module lcd_sequencer import note_lcd_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     freq_strobe,
  input  note_t    note,
  input  logic     ready,
  output lcd_cmd_t cmd,
  output logic     cmd_valid
);

  seq_state_t state, state_nx;
  note_t      note_q;     // Note on display
  logic       start;      // New note accepted
  logic       taken;      // Current byte left with the bus FSM
  logic       byte_done;  // Bus FSM back in idle after it

  assign start     = (state == SEQ_WAIT) && freq_strobe && ready;
  assign byte_done = taken && ready;
  assign cmd_valid = (state != SEQ_WAIT) && !taken;

  ////////////////////////////////////////////////////////////////////////////
  // State register and next state

  always_comb begin
    state_nx = state;
    case (state)
      SEQ_WAIT:   if (start)     state_nx = SEQ_CLEAR;
      SEQ_CLEAR:  if (byte_done) state_nx = SEQ_HOME;
      SEQ_HOME:   if (byte_done) state_nx = SEQ_LETTER;
      SEQ_LETTER: if (byte_done) state_nx = SEQ_NUMBER;
      SEQ_NUMBER: if (byte_done) state_nx = SEQ_WAIT;   // Note complete
      default:    state_nx = SEQ_WAIT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= SEQ_WAIT;
      taken <= 1'b0;
    end else begin
      state <= state_nx;
      if (byte_done) taken <= 1'b0;
      else if (cmd_valid && ready) taken <= 1'b1;  // Bus FSM leaves idle now
    end
  end

  // Strobes outside SEQ_WAIT are dropped
  always_ff @(posedge clk) begin
    if (start) note_q <= note;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte for each state

  always_comb begin
    case (state)
      SEQ_CLEAR:  cmd = '{rs: 1'b0, data: OP_CLEAR};
      SEQ_HOME:   cmd = '{rs: 1'b0, data: OP_HOME};
      SEQ_LETTER: cmd = '{rs: 1'b1, data: note_q.letter};
      SEQ_NUMBER: cmd = '{rs: 1'b1, data: note_q.octave};
      default:    cmd = '{rs: 1'b0, data: 8'h00};
    endcase
  end

endmodule

// File: lcd/lcd_bus_fsm.sv
// HD44780 bus driver; runs the power-up writes, then a set/write/off cycle per accepted byte
module lcd_bus_fsm import note_lcd_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  lcd_cmd_t cmd,
  input  logic     cmd_valid,
  output logic     ready,
  output lcd_bus_t lcd
);

  typedef logic [$clog2(INIT_LEN)-1:0] step_t;

  bus_state_t       state, state_nx;
  logic [CNT_W-1:0] cnt;        // Cycles in current state
  logic [CNT_W-1:0] delay;      // Exit count of current state
  logic             done;
  step_t            step;       // Power-up write index
  logic             last_step;
  lcd_cmd_t         cur;        // Byte on the bus

  assign last_step = (step == step_t'(INIT_LEN - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Delay select and counter compare

  always_comb begin
    case (state)
      BUS_POWERUP:    delay = D_POWERUP;
      BUS_INIT_SET,
      BUS_SET:        delay = D_SETUP;
      BUS_INIT_WRITE,
      BUS_WRITE:      delay = D_ENABLE;
      BUS_INIT_HOLD:  delay = INIT_HOLD[step];
      BUS_OFF:        delay = (!cur.rs && cur.data == OP_CLEAR) ? D_LONG : D_CMD;  // Slow clear
      default:        delay = '0;
    endcase
  end

  assign done = (cnt == delay);  // State with delay N lasts N+1 cycles

  ////////////////////////////////////////////////////////////////////////////
  // Next state

  always_comb begin
    state_nx = state;
    case (state)
      BUS_POWERUP:    if (done) state_nx = BUS_INIT_SET;
      BUS_INIT_SET:   if (done) state_nx = BUS_INIT_WRITE;
      BUS_INIT_WRITE: if (done) state_nx = BUS_INIT_HOLD;
      BUS_INIT_HOLD:  if (done) state_nx = last_step ? BUS_IDLE : BUS_INIT_SET;
      BUS_IDLE:       if (cmd_valid) state_nx = BUS_SET;  // Accept byte
      BUS_SET:        if (done) state_nx = BUS_WRITE;
      BUS_WRITE:      if (done) state_nx = BUS_OFF;
      BUS_OFF:        if (done) state_nx = BUS_IDLE;
      default:        state_nx = BUS_POWERUP;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= BUS_POWERUP;
      cnt   <= '0;
      step  <= '0;
    end else begin
      state <= state_nx;
      // Restart on every state change, park in idle
      if (state_nx != state || state == BUS_IDLE) cnt <= '0;
      else cnt <= cnt + 1'b1;
      if (state == BUS_INIT_HOLD && done) step <= step + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte capture held on d through the whole cycle

  always_ff @(posedge clk) begin
    case (state)
      BUS_POWERUP: cur <= '{rs: 1'b0, data: INIT_OPS[0]};
      BUS_INIT_HOLD: begin
        if (done && !last_step) cur <= '{rs: 1'b0, data: INIT_OPS[step + 1'b1]};
      end
      BUS_IDLE: begin
        if (cmd_valid) cur <= cmd;
      end
      default: cur <= cur;
    endcase
  end

  assign ready  = (state == BUS_IDLE);
  assign lcd.e  = (state == BUS_INIT_WRITE) || (state == BUS_WRITE);  // Enable pulse
  assign lcd.rs = cur.rs;
  assign lcd.d  = cur.data;

endmodule

// File: verilog/note_display_top.sv
// Note display top; SPI frequency in, decoded note written to a character LCD on an 8-bit bus
module note_display_top import note_lcd_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     sclk,
  input  logic     cs,
  input  logic     sdi,
  output lcd_bus_t lcd
);

  freq_t    freq;
  logic     freq_strobe;   // New word, decoder settled
  note_t    note;
  lcd_cmd_t cmd;
  logic     cmd_valid;
  logic     ready;         // Bus FSM idle

  spi_freq_rx i_spi_freq_rx (
    .clk, .reset, .sclk, .sdi, .cs, .freq, .freq_strobe
  );

  note_decoder i_note_decoder (
    .freq, .note
  );

  lcd_sequencer i_lcd_sequencer (
    .clk, .reset, .freq_strobe, .note, .ready, .cmd, .cmd_valid
  );

  // Stalls the sequencer through ready
  lcd_bus_fsm i_lcd_bus_fsm (
    .clk, .reset, .cmd, .cmd_valid, .ready, .lcd
  );

endmodule

// File: testbench/note_display_properties.sv
// Concurrent checks on the LCD bus timing; bound into every lcd_bus_fsm instance below
module note_display_properties import note_lcd_pkg::*; (
  input logic     clk,
  input logic     reset,
  input lcd_bus_t lcd
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [CNT_W-1:0] high_cnt;  // Cycles with e high so far

  always_ff @(posedge clk) begin
    if (reset) high_cnt <= '0;
    else if (lcd.e) high_cnt <= high_cnt + 1'b1;
    else high_cnt <= '0;  // Restart for the next pulse
  end

  // Byte must not move under the enable pulse
  a_bus_stable: assert property (@(posedge clk) disable iff (reset)
    (lcd.e && $past(lcd.e)) |-> $stable({lcd.rs, lcd.d}))
    else $error("LCD d or rs changed while e was high");

  a_enable_width: assert property (@(posedge clk) disable iff (reset)
    $fell(lcd.e) |-> (high_cnt >= D_ENABLE + 1'b1))  // Minimum pulse width
    else $error("LCD e pulse shorter than the enable time");

  a_reset_e_low: assert property (@(posedge clk) reset |=> !lcd.e)
    else $error("LCD e high in the cycle after reset");

endmodule

bind lcd_bus_fsm note_display_properties i_note_display_properties (
  .clk(clk), .reset(reset), .lcd(lcd)
);

// File: testbench/tb_note_display.sv
// Testbench for the note display; sends SPI frames and checks each byte written to the LCD bus
module tb_note_display import note_lcd_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT   = 20000;  // Cycles allowed per wait
  localparam int QUIET_CYCLES = 1500;   // Watch window for stray writes

  logic     clk = 1'b0;
  logic     reset;
  logic     sclk;
  logic     cs;
  logic     sdi;
  lcd_bus_t lcd;

  logic [8:0] got_q[$];   // {rs, d} seen on the bus
  logic [8:0] exp_q[$];   // {rs, d} expected
  string      name_q[$];  // Test name per expected byte
  int got_count     = 0;
  int exp_count     = 0;
  int checks        = 0;
  int value_errors  = 0;
  int other_errors  = 0;
  int cycle         = 0;
  int first_e_cycle = -1;  // Cycle of first enable pulse
  int base;
  logic  e_last = 1'b0;
  freq_t edges [4] = '{16'd62, 16'd69, 16'd70, 16'd1046};
  freq_t outside [4] = '{16'd0, 16'd61, 16'd1047, 16'hFFFF};
  freq_t rand_freq;

  note_display_top i_note_display_top (
    .clk, .reset, .sclk, .cs, .sdi, .lcd
  );

  initial begin
    forever #50 clk = ~clk;  // 100 ns
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and expectation queue

  function automatic note_t note_of(input freq_t f);
    note_t n;
    int    i;
    n = '{letter: CHAR_SPACE, octave: CHAR_SPACE};
    if (f >= NOTE_LOW && f <= NOTE_UPPER[NOTE_COUNT-1]) begin
      i = 0;
      while (f > NOTE_UPPER[i]) i++;  // First bound at or above f
      n.letter = NOTE_LETTERS[i % 7];
      n.octave = OCTAVE_BASE + 8'(i / 7);
    end
    return n;
  endfunction

  task automatic expect_byte(input string name, input logic rs, input logic [7:0] data);
    exp_q.push_back({rs, data});
    name_q.push_back(name);
    exp_count++;
  endtask

  task automatic expect_note(input string name, input freq_t f);
    note_t n;
    n = note_of(f);
    expect_byte(name, 1'b0, OP_CLEAR);
    expect_byte(name, 1'b0, OP_HOME);
    expect_byte(name, 1'b1, n.letter);
    expect_byte(name, 1'b1, n.octave);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, waits and end of run

  task automatic finish_run();
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) $display("Result: PASSED");
    else $display("Result: FAILED");
    $finish;
  endtask

  // MSB first with an sclk period of four clk cycles
  task automatic send_freq(input freq_t f);
    cs = 1'b0;
    for (int b = 15; b >= 0; b--) begin
      sdi  = f[b];
      sclk = 1'b0;
      repeat (2) @(negedge clk);
      sclk = 1'b1;             // Sampled here
      repeat (2) @(negedge clk);
    end
    sclk = 1'b0;
    repeat (2) @(negedge clk);
    cs = 1'b1;                 // Frame end, sclk stays low
    @(negedge clk);
  endtask

  task automatic wait_bytes(input int target, input string what);
    int n;
    n = 0;
    while (got_count < target) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) begin
        $display("Timeout in %s: saw %0d of %0d LCD writes", what, got_count, target);
        other_errors++;
        finish_run();
      end
    end
  endtask

  // Sequencer back in wait and bus idle
  task automatic wait_idle(input string what);
    int n;
    n = 0;
    while (!(i_note_display_top.i_lcd_sequencer.state == SEQ_WAIT &&
             i_note_display_top.ready)) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) begin
        $display("Timeout in %s: display never went back to idle", what);
        other_errors++;
        finish_run();
      end
    end
  endtask

  task automatic run_note(input string name, input freq_t f);
    expect_note(name, f);
    send_freq(f);
    wait_bytes(exp_count, name);
    wait_idle(name);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus monitor and compare

  // Clock cycles since reset release
  always @(posedge clk) begin
    if (reset) cycle = 0;
    else cycle++;
  end

  always @(negedge clk) begin
    if (lcd.e && !e_last) begin  // Rising enable
      got_q.push_back({lcd.rs, lcd.d});
      got_count++;
      if (first_e_cycle < 0) first_e_cycle = cycle;
    end
    e_last = lcd.e;
  end

  always @(posedge clk) begin
    logic [8:0] got;
    logic [8:0] exp;
    string      name;
    while (got_q.size() > 0 && exp_q.size() > 0) begin
      got  = got_q.pop_front();
      exp  = exp_q.pop_front();
      name = name_q.pop_front();
      checks++;
      if (got !== exp) begin
        value_errors++;
        $display("ERROR %s: expected rs=%0b d=0x%02h, actual rs=%0b d=0x%02h",
                 name, exp[8], exp[7:0], got[8], got[7:0]);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    void'($urandom(99976));
    reset = 1'b1;
    sclk  = 1'b0;
    cs    = 1'b1;  // Deselected
    sdi   = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < INIT_LEN; i++) expect_byte("powerup", 1'b0, INIT_OPS[i]);
    wait_bytes(exp_count, "powerup");
    if (first_e_cycle < int'(D_POWERUP)) begin
      other_errors++;
      $display("LCD e rose %0d cycles after reset, before the power-up wait ended",
               first_e_cycle);
    end
    wait_idle("powerup");

    run_note("in range", 16'd440);
    foreach (edges[i]) run_note("table edge", edges[i]);
    foreach (outside[i]) run_note("out of range", outside[i]);

    for (int i = 0; i < 20; i++) begin
      rand_freq = 16'($urandom % 1101);
      run_note("random", rand_freq);
    end

    // Second frame lands during the clear hold
    base = got_count;
    expect_note("dropped frame", 16'd262);
    send_freq(16'd262);
    wait_bytes(base + 1, "dropped frame");
    send_freq(16'd880);
    wait_bytes(base + 4, "dropped frame");
    wait_idle("dropped frame");
    repeat (QUIET_CYCLES) @(negedge clk);
    if (got_count != base + 4) begin
      other_errors++;
      $display("Dropped frame still wrote %0d extra bytes", got_count - base - 4);
    end
    run_note("after drop", 16'd523);

    @(negedge clk);
    if (got_q.size() != 0 || exp_q.size() != 0) begin
      other_errors++;
      $display("Byte count mismatch: %0d unmatched written, %0d unmatched expected",
               got_q.size(), exp_q.size());
    end
    finish_run();
  end

endmodule

// File: all.f
common/note_lcd_pkg.sv
verilog/spi_freq_rx.sv
verilog/note_decoder.sv
lcd/lcd_sequencer.sv
lcd/lcd_bus_fsm.sv
verilog/note_display_top.sv
testbench/note_display_properties.sv
testbench/tb_note_display.sv

// File: run.sh
#!/bin/sh
# Build and run the note display testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_note_display -f all.f -o sim_note_display
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_note_display > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
exit 1
